// ==== Makefile ====
# Verilator simulation of the DRAM read-return path.
LOG := sim.log

sim:
	verilator --binary --timing --assert -f flist.f --top-module dram_rx_tb -o sim_dram_rx
	./obj_dir/sim_dram_rx | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== flist.f ====
logic/dram_rx_pkg.sv
logic/dram_rx_reorder.sv
logic/dram_rx_serializer.sv
logic/dram_rx_fill_tagger.sv
logic/dram_rx_top.sv
verif/dram_rx_properties.sv
verif/dram_rx_tb.sv

// ==== logic/dram_rx_fill_tagger.sv ====
/*
 * Refill word tagger.
 * Output register that numbers the words of a block and flags the last one.
 */
`timescale 1ns/1ps

module dram_rx_fill_tagger (
  input  logic                                      core_clk_i,
  input  logic                                      core_reset_i,

  input  logic                                      word_v_i,
  input  logic [dram_rx_pkg::dma_data_width_lp-1:0] word_i,
  output logic                                      word_ready_o,

  output logic                                      refill_v_o,
  output dram_rx_pkg::refill_word_s                 refill_o,
  input  logic                                      refill_ready_i
);

  import dram_rx_pkg::*;

  logic                           valid_r;
  refill_word_s                   refill_r;
  logic [word_idx_width_lp-1:0]   cnt_r;
  logic                           word_take;

  assign refill_v_o = valid_r;
  assign refill_o   = refill_r;

  // the register can load when it is empty or draining this cycle.
  assign word_ready_o = ~valid_r | refill_ready_i;
  assign word_take    = word_v_i & word_ready_o;

  // the counter wraps at the block size, so the index restarts on its own.
  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      valid_r <= 1'b0;
      cnt_r   <= '0;
    end else if (word_take) begin
      valid_r <= 1'b1;
      cnt_r   <= cnt_r + 1'b1;
    end else if (refill_ready_i) begin
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (word_take) begin
      refill_r.data <= word_i;
      refill_r.idx  <= cnt_r;
      refill_r.last <= (cnt_r == word_idx_width_lp'(words_per_block_lp - 1));
    end
  end

endmodule

// ==== logic/dram_rx_pkg.sv ====
/*
 * DRAM read-return package.
 * Widths, the beat union and the stage structs of the refill return path.
 */
package dram_rx_pkg;

  localparam int dram_data_width_lp   = 128;
  localparam int dma_data_width_lp    = 32;
  localparam int words_per_beat_lp    = 4;
  localparam int beats_per_block_lp   = 4;
  localparam int words_per_block_lp   = 16;
  localparam int dram_addr_width_lp   = 28;
  localparam int beat_offset_width_lp = 4;
  localparam int beat_idx_width_lp    = 2;
  localparam int word_idx_width_lp    = 4;

  // a beat is moved whole by the reorder stage and picked apart by the serializer.
  // words[0] is the least significant 32 bits of the wide view.
  typedef union packed {
    logic [dram_data_width_lp-1:0]                         wide;
    logic [words_per_beat_lp-1:0][dma_data_width_lp-1:0]   words;
  } dram_beat_u;

  // one arrival from the DRAM model.
  typedef struct packed {
    dram_beat_u                      beat;
    logic [dram_addr_width_lp-1:0]   addr;
  } dram_rx_s;

  // one word as presented at the refill port.
  typedef struct packed {
    logic [dma_data_width_lp-1:0]   data;
    logic [word_idx_width_lp-1:0]   idx;
    logic                           last;
  } refill_word_s;

endpackage

// ==== logic/dram_rx_reorder.sv ====
/*
 * DRAM return reorder stage.
 * Puts the beats of one block back into address order with a slot per beat.
 */
`timescale 1ns/1ps

module dram_rx_reorder (
  input  logic                     core_clk_i,
  input  logic                     core_reset_i,

  input  logic                     dram_v_i,
  input  dram_rx_pkg::dram_rx_s    dram_rx_i,

  output logic                     beat_v_o,
  output dram_rx_pkg::dram_beat_u  beat_o,
  input  logic                     beat_ready_i
);

  import dram_rx_pkg::*;

  logic [beat_idx_width_lp-1:0]   beat_idx;
  logic [beat_idx_width_lp-1:0]   count_r;

  // slot storage holds payload only. The valid bits carry the state.
  dram_beat_u                     slot_r [beats_per_block_lp];
  logic [beats_per_block_lp-1:0]  slot_v_r;

  logic hit_buf;
  logic hit_wire;
  logic pass_wire;
  logic beat_xfer;
  logic last_beat;
  logic slot_we;

  // the beat number sits just above the byte offset within the beat.
  assign beat_idx = dram_rx_i.addr[beat_offset_width_lp +: beat_idx_width_lp];

  // the expected beat may already wait in its slot, or arrive right now.
  assign hit_buf  = slot_v_r[count_r];
  assign hit_wire = dram_v_i & (beat_idx == count_r);

  // a buffered expected beat wins over the wire.
  assign beat_v_o = hit_buf | hit_wire;
  assign beat_o   = hit_buf ? slot_r[count_r] : dram_rx_i.beat;

  assign beat_xfer = beat_v_o & beat_ready_i;
  assign last_beat = (count_r == beat_idx_width_lp'(beats_per_block_lp - 1));

  // the arrival goes straight through only when it is expected, nothing
  // buffered is ahead of it, and the serializer takes it this cycle.
  assign pass_wire = hit_wire & ~hit_buf & beat_ready_i;

  // everything else that arrives is parked in its own slot.
  assign slot_we = dram_v_i & ~pass_wire;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      count_r <= '0;
    end else if (beat_xfer) begin
      if (last_beat) begin
        count_r <= '0;
      end else begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  // once the last beat leaves, the block is done and every slot is free.
  // the DRAM model holds off the next block until then, so a write can
  // never collide with the clear.
  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      slot_v_r <= '0;
    end else if (beat_xfer & last_beat) begin
      slot_v_r <= '0;
    end else if (slot_we) begin
      slot_v_r[beat_idx] <= 1'b1;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (slot_we) begin
      slot_r[beat_idx] <= dram_rx_i.beat;
    end
  end

endmodule

// ==== logic/dram_rx_serializer.sv ====
/*
 * Beat to word serializer.
 * Holds one DRAM beat and offers its refill words from word 0 upward.
 */
`timescale 1ns/1ps

module dram_rx_serializer (
  input  logic                                 core_clk_i,
  input  logic                                 core_reset_i,

  input  logic                                 beat_v_i,
  input  dram_rx_pkg::dram_beat_u              beat_i,
  output logic                                 beat_ready_o,

  output logic                                 word_v_o,
  output logic [dram_rx_pkg::dma_data_width_lp-1:0] word_o,
  input  logic                                 word_ready_i
);

  import dram_rx_pkg::*;

  dram_beat_u                            beat_r;
  logic                                  full_r;
  logic [$clog2(words_per_beat_lp)-1:0]  ptr_r;

  logic word_xfer;
  logic last_word;
  logic beat_take;

  assign word_v_o = full_r;
  assign word_o   = beat_r.words[ptr_r];

  assign word_xfer = word_v_o & word_ready_i;
  assign last_word = (ptr_r == $clog2(words_per_beat_lp)'(words_per_beat_lp - 1));

  // the next beat can come in as the last word of this one leaves,
  // so consecutive beats stream without a bubble.
  assign beat_ready_o = ~full_r | (word_xfer & last_word);
  assign beat_take    = beat_v_i & beat_ready_o;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      full_r <= 1'b0;
      ptr_r  <= '0;
    end else if (beat_take) begin
      full_r <= 1'b1;
      ptr_r  <= '0;
    end else if (word_xfer) begin
      ptr_r <= ptr_r + 1'b1;
      if (last_word) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (beat_take) begin
      beat_r <= beat_i;
    end
  end

endmodule

// ==== logic/dram_rx_top.sv ====
/*
 * DRAM read-return pipeline top.
 * Chains the reorder, serializer and tagger stages for cache refill.
 */
`timescale 1ns/1ps

module dram_rx_top (
  input  logic                       core_clk_i,
  input  logic                       core_reset_i,

  input  logic                       dram_v_i,
  input  dram_rx_pkg::dram_rx_s      dram_rx_i,

  output logic                       refill_v_o,
  output dram_rx_pkg::refill_word_s  refill_o,
  input  logic                       refill_ready_i
);

  import dram_rx_pkg::*;

  logic                           beat_v;
  dram_beat_u                     beat;
  logic                           beat_ready;

  logic                           word_v;
  logic [dma_data_width_lp-1:0]   word;
  logic                           word_ready;

  dram_rx_reorder u_reorder (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .dram_v_i     (dram_v_i),
    .dram_rx_i    (dram_rx_i),
    .beat_v_o     (beat_v),
    .beat_o       (beat),
    .beat_ready_i (beat_ready)
  );

  dram_rx_serializer u_serializer (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .beat_v_i     (beat_v),
    .beat_i       (beat),
    .beat_ready_o (beat_ready),
    .word_v_o     (word_v),
    .word_o       (word),
    .word_ready_i (word_ready)
  );

  dram_rx_fill_tagger u_tagger (
    .core_clk_i     (core_clk_i),
    .core_reset_i   (core_reset_i),
    .word_v_i       (word_v),
    .word_i         (word),
    .word_ready_o   (word_ready),
    .refill_v_o     (refill_v_o),
    .refill_o       (refill_o),
    .refill_ready_i (refill_ready_i)
  );

endmodule

// ==== verif/dram_rx_properties.sv ====
/*
 * Handshake and slot assertions, bound to the reorder stage and the top.
 */
`timescale 1ns/1ps

module dram_rx_properties (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       slot_we_i,
  input  logic                                       slot_busy_i,
  input  logic                                       v_i,
  input  logic                                       ready_i,
  input  logic [dram_rx_pkg::dram_data_width_lp-1:0] data_i,
  input  logic                                       out_v_i,
  input  logic [dram_rx_pkg::word_idx_width_lp-1:0]  out_idx_i,
  input  logic                                       out_last_i
);

  import dram_rx_pkg::*;

  // only one block is in flight, so each slot is filled at most once.
  slot_free: assert property (@(posedge clk_i) disable iff (reset_i)
    slot_we_i |-> !slot_busy_i)
    else $error("slot written while it still holds a beat");

  stage_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i && !ready_i |=> v_i && $stable(data_i))
    else $error("valid dropped or data changed before ready");

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !out_v_i)
    else $error("refill valid high right after reset");

  last_on_final: assert property (@(posedge clk_i) disable iff (reset_i)
    out_v_i && out_last_i |-> out_idx_i == word_idx_width_lp'(words_per_block_lp - 1))
    else $error("last flag on a word other than the final one");

endmodule

bind dram_rx_reorder dram_rx_properties u_reorder_props (
  .clk_i       (core_clk_i),
  .reset_i     (core_reset_i),
  .slot_we_i   (slot_we),
  .slot_busy_i (slot_v_r[beat_idx]),
  .v_i         (beat_v_o),
  .ready_i     (beat_ready_i),
  .data_i      (beat_o),
  .out_v_i     (1'b0),
  .out_idx_i   (4'd0),
  .out_last_i  (1'b0)
);

bind dram_rx_top dram_rx_properties u_top_props (
  .clk_i       (core_clk_i),
  .reset_i     (core_reset_i),
  .slot_we_i   (1'b0),
  .slot_busy_i (1'b0),
  .v_i         (refill_v_o),
  .ready_i     (refill_ready_i),
  .data_i      ({91'd0, refill_o}),
  .out_v_i     (refill_v_o),
  .out_idx_i   (refill_o.idx),
  .out_last_i  (refill_o.last)
);

// ==== verif/dram_rx_tb.sv ====
/*
 * Testbench for the DRAM read-return pipeline.
 * Sends table blocks out of order and checks the tagged refill words.
 */
`timescale 1ns/1ps

module dram_rx_tb;

  import dram_rx_pkg::*;

  // one block of stimulus. The order and gap nibbles are read from the top down.
  typedef struct packed {
    logic [dram_addr_width_lp-1:0]                        base;
    logic [beats_per_block_lp-1:0][dram_data_width_lp-1:0] beats;
    logic [beats_per_block_lp-1:0][3:0]                   order;
    logic [beats_per_block_lp-1:0][3:0]                   gap;
    logic                                                 bp;
  } block_row_s;

  logic          core_clk_i;
  logic          core_reset_i;
  logic          dram_v_i;
  dram_rx_s      dram_rx_i;
  logic          refill_v_o;
  refill_word_s  refill_o;
  logic          refill_ready_i;

  block_row_s    tbl[$];
  integer        seed = 91;
  int            errors = 0;
  int            checks = 0;
  int            words_total = 0;
  logic          timed_out = 1'b0;

  dram_rx_top uut (
    .core_clk_i     (core_clk_i),
    .core_reset_i   (core_reset_i),
    .dram_v_i       (dram_v_i),
    .dram_rx_i      (dram_rx_i),
    .refill_v_o     (refill_v_o),
    .refill_o       (refill_o),
    .refill_ready_i (refill_ready_i)
  );

  initial begin
    core_clk_i = 1'b0;
    forever #10 core_clk_i = ~core_clk_i;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  // beat data carries the row, beat and word numbers so that a swap shows up.
  task automatic add_row(input logic [27:0] base, input logic [15:0] order,
                         input logic [15:0] gap, input logic bp);
    block_row_s row;
    row.base  = base;
    row.order = order;
    row.gap   = gap;
    row.bp    = bp;
    for (int b = 0; b < 4; b++) begin
      for (int w = 0; w < 4; w++) begin
        row.beats[2'(b)][{2'(w), 5'd0} +: 32] =
          {8'(tbl.size()) ^ 8'h5a, 4'(b), 4'(w), base[21:6]};
      end
    end
    tbl.push_back(row);
  endtask

  task automatic send_block(input int r);
    logic [1:0] bsel;
    for (int i = 0; i < 4; i++) begin
      for (int g = 0; g < int'(tbl[r].gap[2'(3 - i)]); g++) begin
        @(negedge core_clk_i);
        dram_v_i = 1'b0;
      end
      bsel = tbl[r].order[2'(3 - i)][1:0];
      @(negedge core_clk_i);
      dram_v_i            = 1'b1;
      dram_rx_i.addr      = {tbl[r].base[dram_addr_width_lp-1:6], bsel, 4'h0};
      dram_rx_i.beat.wide = tbl[r].beats[bsel];
    end
    @(negedge core_clk_i);
    dram_v_i = 1'b0;
  endtask

  // outputs are register driven, so the falling edge sees them settled.
  task automatic collect_block(input int r);
    int          got_n;
    int          waited;
    logic [3:0]  kidx;
    logic [31:0] exp_data;
    got_n  = 0;
    waited = 0;
    while (got_n < words_per_block_lp && !timed_out) begin
      @(negedge core_clk_i);
      if (tbl[r].bp) begin
        refill_ready_i = ($random(seed) % 4) != 0;
      end else begin
        refill_ready_i = 1'b1;
      end
      if (refill_v_o && refill_ready_i) begin
        kidx     = 4'(got_n);
        exp_data = tbl[r].beats[kidx[3:2]][{kidx[1:0], 5'd0} +: 32];
        compare_value("refill_o.data", refill_o.data, exp_data);
        compare_value("refill_o.idx", 32'(refill_o.idx), 32'(kidx));
        compare_value("refill_o.last", 32'(refill_o.last), 32'(kidx == 4'd15));
        got_n++;
        words_total++;
        waited = 0;
      end else begin
        waited++;
        if (waited > 100) begin
          $display("ERROR: block %0d stalled, no refill word for 100 cycles after %0d words",
                   r, got_n);
          errors++;
          timed_out = 1'b1;
        end
      end
    end
    refill_ready_i = 1'b1;
  endtask

  initial begin
    core_reset_i   = 1'b1;
    dram_v_i       = 1'b0;
    dram_rx_i      = '0;
    refill_ready_i = 1'b1;

    add_row(28'h0000040, 16'h0123, 16'h0000, 1'b0);
    add_row(28'h0001a80, 16'h3210, 16'h0000, 1'b0);
    add_row(28'h0023c00, 16'h2031, 16'h1020, 1'b0);
    add_row(28'h0400140, 16'h1302, 16'h0000, 1'b1);
    add_row(28'h00fffc0, 16'h0213, 16'h3102, 1'b1);
    add_row(28'h0abcd00, 16'h3012, 16'h0000, 1'b1);
    add_row(28'h7ffffc0, 16'h0123, 16'h0101, 1'b1);

    repeat (16) @(negedge core_clk_i);
    core_reset_i = 1'b0;

    // nothing has arrived yet, so the refill port must stay quiet.
    repeat (8) begin
      @(negedge core_clk_i);
      compare_value("refill_v_o", 32'(refill_v_o), 32'd0);
    end

    for (int r = 0; r < tbl.size() && !timed_out; r++) begin
      fork
        send_block(r);
        collect_block(r);
      join
    end

    // an extra word after the last block would be a duplicate.
    if (!timed_out) begin
      repeat (8) begin
        @(negedge core_clk_i);
        compare_value("refill_v_o", 32'(refill_v_o), 32'd0);
      end
    end

    $display("checks %0d, words %0d, errors %0d", checks, words_total, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
